// File: src.f
logic/corner_pkg.sv
logic/clause_store.sv
logic/clause_reduce.sv
logic/bound_tree.sv
logic/corner_propose.sv
bench/corner_propose_assertions.sv
bench/corner_propose_tb.sv

// File: Bender.yml
package:
  name: corner_propose

sources:
  # design, package first
  - files:
      - logic/corner_pkg.sv
      - logic/clause_store.sv
      - logic/clause_reduce.sv
      - logic/bound_tree.sv
      - logic/corner_propose.sv

  # testbench and bound checks
  - target: test
    files:
      - bench/corner_propose_assertions.sv
      - bench/corner_propose_tb.sv

// File: bench/corner_propose_tb.sv
module corner_propose_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CLAUSES = 8;
    localparam int IDX_BITS    = $clog2(NUM_CLAUSES);
    localparam int NUM_RANDOM  = 30;
    localparam int LATENCY     = 2;  // propose edge to proposal_valid

    // one table row holds a clause write or a propose
    typedef struct packed {
        logic                    is_write;
        logic                    from_model;  // random row checked against the model only
        logic [3:0]              group;       // behavior under test (7 for random rows)
        logic [IDX_BITS-1:0]     index;
        corner_pkg::clause_t     clause;
        corner_pkg::assignment_t assignment;
        corner_pkg::var_idx_t    move_var;
        logic [NUM_CLAUSES-1:0]  enable;
        corner_pkg::value_t      exp_value;
        logic                    exp_found;
    } step_t;

    typedef struct packed {
        int                 test_id;
        int                 issue_cycle;
        logic [3:0]         group;
        corner_pkg::value_t value;
        logic               found;
    } pending_t;

    typedef struct packed {
        corner_pkg::value_t value;
        logic               found;
    } result_t;

    logic                    clk;
    logic                    reset;
    logic                    clause_write;
    logic [IDX_BITS-1:0]     clause_index;
    corner_pkg::clause_t     clause_data;
    logic                    propose;
    corner_pkg::assignment_t assignment;
    corner_pkg::var_idx_t    move_var;
    logic [NUM_CLAUSES-1:0]  enable;
    corner_pkg::value_t      proposal;
    logic                    proposal_found;
    logic                    proposal_valid;

    step_t               steps [$];
    pending_t            pending [$];
    corner_pkg::clause_t model_clauses [NUM_CLAUSES];  // mirror of the clause store
    corner_pkg::value_t  model_last;                   // last proposal the DUT should hold

    int seed            = int'(32'he793_843a);
    int cycle_count     = 0;
    int max_cycles      = 1000;  // replaced once the table is built
    int tests_run       = 0;
    int tests_failed    = 0;
    int other_errors    = 0;
    int proposes_issued = 0;

    corner_propose #(
        .NUM_CLAUSES (NUM_CLAUSES)
    ) i_dut (
        .clk            (clk),
        .reset          (reset),
        .clause_write   (clause_write),
        .clause_index   (clause_index),
        .clause_data    (clause_data),
        .propose        (propose),
        .assignment     (assignment),
        .move_var       (move_var),
        .enable         (enable),
        .proposal       (proposal),
        .proposal_found (proposal_found),
        .proposal_valid (proposal_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: stopped after %0d cycles with %0d results outstanding",
                     cycle_count, pending.size());
            $display("Test failed");
            $finish;
        end
    end

    function automatic corner_pkg::clause_t make_clause(input int c0, input int c1,
                                                        input int c2, input int c3,
                                                        input int bias);
        corner_pkg::clause_t c;
        c.coef[0] = corner_pkg::coef_t'(c0);
        c.coef[1] = corner_pkg::coef_t'(c1);
        c.coef[2] = corner_pkg::coef_t'(c2);
        c.coef[3] = corner_pkg::coef_t'(c3);
        c.bias    = corner_pkg::coef_t'(bias);
        return c;
    endfunction

    function automatic int clamp_to_value(input int v);
        if (v > 127) begin
            return 127;
        end else if (v < -128) begin
            return -128;
        end
        return v;
    endfunction

    // expected result of one propose against the mirrored clauses
    function automatic result_t model_propose(input step_t s, input corner_pkg::value_t previous);
        corner_pkg::clause_t c;
        corner_pkg::coef_t   mc;
        result_t             r;
        int                  residual;
        int                  best_lo;
        int                  best_hi;
        logic                have_lo;
        logic                have_hi;
        have_lo = 1'b0;
        have_hi = 1'b0;
        best_lo = -1000;
        best_hi = 1000;
        for (int i = 0; i < NUM_CLAUSES; i++) begin
            c  = model_clauses[i];
            mc = c.coef[s.move_var];
            if (s.enable[i] && mc != 0) begin
                residual = int'($signed(c.bias));
                for (int k = 0; k < corner_pkg::NUM_VARS; k++) begin
                    if (k != int'(s.move_var)) begin
                        residual += int'($signed(c.coef[k])) * int'($signed(s.assignment[k]));
                    end
                end
                if ($signed(mc) > 0) begin  // only the sign of the moved coefficient counts
                    have_lo = 1'b1;
                    best_lo = (clamp_to_value(1 - residual) > best_lo) ?
                              clamp_to_value(1 - residual) : best_lo;
                end else begin
                    have_hi = 1'b1;
                    best_hi = (clamp_to_value(residual - 1) < best_hi) ?
                              clamp_to_value(residual - 1) : best_hi;
                end
            end
        end
        r.found = have_lo || have_hi;
        if (have_lo) begin
            r.value = corner_pkg::value_t'(best_lo);
        end else if (have_hi) begin
            r.value = corner_pkg::value_t'(best_hi);
        end else begin
            r.value = previous;
        end
        return r;
    endfunction

    task automatic add_write(input int idx, input int c0, input int c1, input int c2,
                             input int c3, input int bias);
        step_t s;
        s          = '0;
        s.is_write = 1'b1;
        s.index    = IDX_BITS'(idx);
        s.clause   = make_clause(c0, c1, c2, c3, bias);
        steps.push_back(s);
    endtask

    task automatic add_propose(input int group, input int x0, input int x1, input int x2,
                               input int x3, input int mv, input logic [NUM_CLAUSES-1:0] en,
                               input int exp_value, input logic exp_found);
        step_t s;
        s               = '0;
        s.group         = 4'(group);
        s.assignment[0] = corner_pkg::value_t'(x0);
        s.assignment[1] = corner_pkg::value_t'(x1);
        s.assignment[2] = corner_pkg::value_t'(x2);
        s.assignment[3] = corner_pkg::value_t'(x3);
        s.move_var      = corner_pkg::var_idx_t'(mv);
        s.enable        = en;
        s.exp_value     = corner_pkg::value_t'(exp_value);
        s.exp_found     = exp_found;
        steps.push_back(s);
    endtask

    task automatic add_random_steps(input int count);
        step_t s;
        int    r;
        for (int n = 0; n < count; n++) begin
            s            = '0;
            s.from_model = 1'b1;
            s.group      = 4'd7;
            r            = $random(seed);
            if (r[1:0] == 2'd0) begin  // roughly one row in four rewrites a clause
                s.is_write = 1'b1;
                s.index    = IDX_BITS'($random(seed));
                for (int k = 0; k < corner_pkg::NUM_VARS; k++) begin
                    r           = {$random(seed)} % 3;
                    s.clause.coef[k] = corner_pkg::coef_t'(r - 1);
                end
                s.clause.bias = corner_pkg::coef_t'($random(seed));
            end else begin
                for (int k = 0; k < corner_pkg::NUM_VARS; k++) begin
                    s.assignment[k] = corner_pkg::value_t'($random(seed));
                end
                s.move_var = corner_pkg::var_idx_t'($random(seed));
                s.enable   = NUM_CLAUSES'($random(seed));
            end
            steps.push_back(s);
        end
    endtask

    task automatic build_table();
        add_propose(6, 0, 0, 0, 0, 0, 8'hff, 0, 1'b0);  // cleared store gives no active bound
        add_write(0, 1, 1, 0, 0, 0);
        add_write(1, 1, 0, -1, 0, 2);
        add_write(2, 1, 0, 0, 1, -5);
        add_propose(1, 0, 3, 4, 1, 0, 8'b0000_0111, 5, 1'b1);  // lower bounds -2, 3, 5
        add_write(3, 0, -1, 0, 1, 6);
        add_write(4, 1, -1, 0, 0, 0);
        add_propose(2, 2, 0, 0, -1, 1, 8'b0001_1000, 1, 1'b1);  // upper bounds 4 and 1
        add_propose(1, 2, 0, 0, -1, 1, 8'b0001_1001, -1, 1'b1); // lower bound beats uppers
        add_propose(3, 0, 3, 4, 1, 0, 8'b0000_0011, 3, 1'b1);   // clause 2 disabled
        add_propose(3, 0, 3, 4, 1, 0, 8'b0000_1000, 3, 1'b0);   // clause 3 alone has zero coef
        add_propose(4, 0, 3, 4, 1, 1, 8'b0000_0110, 3, 1'b0);
        add_propose(4, 0, 3, 4, 1, 2, 8'b0000_0000, 3, 1'b0);
        // back to back proposes and rewrites in flight
        add_propose(5, 0, 3, 4, 1, 0, 8'b0000_0111, 5, 1'b1);
        add_propose(5, 1, 0, 0, 0, 2, 8'b0000_0010, 2, 1'b1);
        add_write(2, 1, 0, 0, 0, -9);
        add_propose(5, 0, 3, 4, 1, 0, 8'b0000_0111, 10, 1'b1);
        add_propose(5, 0, 3, 4, 1, 0, 8'b0000_0100, 10, 1'b1);
        add_write(2, 1, 0, 0, 0, 0);
        add_propose(5, 0, 3, 4, 1, 0, 8'b0000_0100, 1, 1'b1);
        // saturation at both ends
        add_write(5, 1, 1, 1, 0, -100);
        add_propose(6, 0, -100, -100, 0, 0, 8'b0010_0000, 127, 1'b1);
        add_write(6, -1, 1, 1, 1, -100);
        add_propose(6, 0, -100, -100, -100, 0, 8'b0100_0000, -128, 1'b1);
        add_propose(6, 0, -100, -100, -100, 0, 8'b0110_0000, 127, 1'b1);
        // magnitudes other than one act by sign
        add_write(7, 3, 2, 0, 0, 1);
        add_propose(1, 0, 5, 0, 0, 0, 8'b1000_0000, -10, 1'b1);
        add_write(7, -5, 0, 0, 0, 20);
        add_propose(2, 9, 0, 0, 0, 0, 8'b1000_0000, 19, 1'b1);
        add_random_steps(NUM_RANDOM);
    endtask

    task automatic report_test(input pending_t p, input logic ok);
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test %0d (%s): proposal %0d found %0b %s", p.test_id,
                 (p.group == 4'd7) ? "random" : $sformatf("behavior %0d", p.group),
                 proposal, proposal_found, ok ? "ok" : "FAIL");
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        pending_t p;
        logic     ok;
        if (!reset) begin
            if (proposal_valid) begin
                if (pending.size() == 0) begin
                    $display("proposal_valid pulsed at %t with no propose outstanding", $time);
                    other_errors++;
                end else begin
                    p  = pending.pop_front();
                    ok = 1'b1;
                    assert (cycle_count == p.issue_cycle + LATENCY) else begin
                        $display("error: %t: test %0d result after %0d cycles, expected %0d",
                                 $time, p.test_id, cycle_count - p.issue_cycle, LATENCY);
                        ok = 1'b0;
                    end
                    assert (proposal_found == p.found) else begin
                        $display("error: %t: test %0d found %0b, expected %0b",
                                 $time, p.test_id, proposal_found, p.found);
                        ok = 1'b0;
                    end
                    assert (proposal == p.value) else begin
                        $display("error: %t: test %0d proposal %0d, expected %0d",
                                 $time, p.test_id, proposal, p.value);
                        ok = 1'b0;
                    end
                    report_test(p, ok);
                end
            end else if (pending.size() > 0 &&
                         cycle_count >= pending[0].issue_cycle + LATENCY) begin
                p = pending.pop_front();
                $display("proposal_valid never came for test %0d after its propose", p.test_id);
                report_test(p, 1'b0);
            end
        end
    end

    initial begin
        step_t    step;
        result_t  expected;
        pending_t p;
        int       total_other;
        $timeformat(-9, 1, " ns", 0);
        reset        = 1'b1;
        clause_write = 1'b0;
        clause_index = '0;
        clause_data  = '0;
        propose      = 1'b0;
        assignment   = '0;
        move_var     = '0;
        enable       = '0;
        model_last   = '0;
        for (int i = 0; i < NUM_CLAUSES; i++) begin
            model_clauses[i] = '0;
        end
        build_table();
        max_cycles = 2 * steps.size() + 50;

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        for (int n = 0; n < steps.size(); n++) begin
            step = steps[n];
            @(posedge clk);
            #1;
            clause_write = 1'b0;
            propose      = 1'b0;
            if (step.is_write) begin
                clause_write                = 1'b1;
                clause_index                = step.index;
                clause_data                 = step.clause;
                model_clauses[step.index]   = step.clause;  // seen by the next propose
            end else begin
                expected = model_propose(step, model_last);
                if (!step.from_model) begin
                    assert (expected == {step.exp_value, step.exp_found}) else begin
                        $display("error: %t: table row %0d expects %0d/%0b, model gives %0d/%0b",
                                 $time, n, step.exp_value, step.exp_found,
                                 expected.value, expected.found);
                        other_errors++;
                    end
                end
                model_last    = expected.value;
                p.test_id     = proposes_issued;
                p.issue_cycle = cycle_count;
                p.group       = step.group;
                p.value       = expected.value;
                p.found       = expected.found;
                pending.push_back(p);
                proposes_issued++;
                propose    = 1'b1;
                assignment = step.assignment;
                move_var   = step.move_var;
                enable     = step.enable;
            end
        end
        @(posedge clk);
        #1;
        clause_write = 1'b0;
        propose      = 1'b0;

        while (pending.size() > 0) begin
            @(negedge clk);
        end
        @(negedge clk);

        total_other = other_errors + i_dut.i_bound_tree.i_tree_checks.failures;
        $display("%0d tests run, %0d passed, %0d failed, %0d other errors", tests_run,
                 tests_run - tests_failed, tests_failed, total_other);
        if (tests_failed == 0 && total_other == 0 && tests_run == proposes_issued) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: bench/corner_propose_assertions.sv
module corner_propose_assertions (
    input logic               clk,
    input logic               reset,
    input logic               bounds_valid,
    input corner_pkg::value_t proposal,
    input logic               proposal_found,
    input logic               proposal_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;  // summed into the testbench totals

    valid_follows: assert property (@(posedge clk) disable iff (reset)
        bounds_valid |=> proposal_valid)
        else begin $error("proposal_valid missing one cycle after bounds_valid"); failures++; end

    no_stray_valid: assert property (@(posedge clk) disable iff (reset)
        !bounds_valid |=> !proposal_valid)
        else begin $error("proposal_valid without bounds_valid"); failures++; end

    found_needs_valid: assert property (@(posedge clk) proposal_found |-> proposal_valid)
        else begin $error("proposal_found high outside a valid pulse"); failures++; end

    // synchronous reset clears the result registers at the next edge
    reset_clears: assert property (@(posedge clk)
        reset |=> (!proposal_valid && !proposal_found && proposal == '0))
        else begin $error("outputs not cleared by reset"); failures++; end

endmodule

bind bound_tree corner_propose_assertions i_tree_checks (
    .clk            (clk),
    .reset          (reset),
    .bounds_valid   (bounds_valid),
    .proposal       (proposal),
    .proposal_found (proposal_found),
    .proposal_valid (proposal_valid)
);

// File: logic/corner_propose.sv
module corner_propose #(
    parameter int  NUM_CLAUSES = 8,
    localparam int IDX_BITS    = $clog2(NUM_CLAUSES)
) (
    input  logic                    clk,
    input  logic                    reset,

    // clause setup
    input  logic                    clause_write,
    input  logic [IDX_BITS-1:0]     clause_index,
    input  corner_pkg::clause_t     clause_data,

    // one move request per pulse
    input  logic                    propose,
    input  corner_pkg::assignment_t assignment,
    input  corner_pkg::var_idx_t    move_var,
    input  logic [NUM_CLAUSES-1:0]  enable,

    output corner_pkg::value_t      proposal,
    output logic                    proposal_found,
    output logic                    proposal_valid
);

    corner_pkg::clause_t clauses [NUM_CLAUSES];
    corner_pkg::bound_t  bounds  [NUM_CLAUSES];
    logic                bounds_valid;  // propose, aligned with the bound registers

    always_ff @(posedge clk) begin
        if (reset) begin
            bounds_valid <= 1'b0;
        end else begin
            bounds_valid <= propose;
        end
    end

    clause_store #(
        .NUM_CLAUSES (NUM_CLAUSES)
    ) i_clause_store (
        .clk          (clk),
        .reset        (reset),
        .clause_write (clause_write),
        .clause_index (clause_index),
        .clause_data  (clause_data),
        .clauses      (clauses)
    );

    // every clause reduces in parallel against the same assignment
    for (genvar i = 0; i < NUM_CLAUSES; i++) begin : gen_reduce
        clause_reduce i_clause_reduce (
            .clk        (clk),
            .reset      (reset),
            .propose    (propose),
            .clause     (clauses[i]),
            .assignment (assignment),
            .move_var   (move_var),
            .enable     (enable[i]),
            .bound      (bounds[i])
        );
    end

    bound_tree #(
        .NUM_CLAUSES (NUM_CLAUSES)
    ) i_bound_tree (
        .clk            (clk),
        .reset          (reset),
        .bounds_valid   (bounds_valid),
        .bounds         (bounds),
        .proposal       (proposal),
        .proposal_found (proposal_found),
        .proposal_valid (proposal_valid)
    );

endmodule

// File: logic/bound_tree.sv
module bound_tree #(
    parameter int  NUM_CLAUSES = 8,
    localparam int LEVELS      = $clog2(NUM_CLAUSES),
    localparam int NODES       = 2 * NUM_CLAUSES
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               bounds_valid,  // propose delayed by one cycle
    input  corner_pkg::bound_t bounds [NUM_CLAUSES],
    output corner_pkg::value_t proposal,
    output logic               proposal_found,
    output logic               proposal_valid
);

    // heap layout, root at 1, leaves at NUM_CLAUSES .. NODES-1
    corner_pkg::value_t lo_val [1:NODES-1];  // largest lower bound so far
    logic               lo_act [1:NODES-1];
    corner_pkg::value_t hi_val [1:NODES-1];  // smallest upper bound so far
    logic               hi_act [1:NODES-1];

    logic               any_bound;

    // split every leaf into its lower and upper role
    for (genvar i = 0; i < NUM_CLAUSES; i++) begin : gen_leaf
        assign lo_val[NUM_CLAUSES+i] = bounds[i].value;
        assign lo_act[NUM_CLAUSES+i] = bounds[i].active && bounds[i].lower;
        assign hi_val[NUM_CLAUSES+i] = bounds[i].value;
        assign hi_act[NUM_CLAUSES+i] = bounds[i].active && !bounds[i].lower;
    end

    // one comparator pair per inner node, level 0 is the root
    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : gen_level
        for (genvar j = 0; j < 2 ** lvl; j++) begin : gen_node
            localparam int K = 2 ** lvl + j;
            localparam int L = 2 * K;  // left child
            localparam int R = 2 * K + 1;  // right child

            logic lo_take_left;
            logic hi_take_left;

            // an inactive side always loses
            assign lo_take_left = lo_act[L] && (!lo_act[R] || (lo_val[L] > lo_val[R]));
            assign hi_take_left = hi_act[L] && (!hi_act[R] || (hi_val[L] < hi_val[R]));

            assign lo_act[K] = lo_act[L] || lo_act[R];
            assign lo_val[K] = lo_take_left ? lo_val[L] : lo_val[R];
            assign hi_act[K] = hi_act[L] || hi_act[R];
            assign hi_val[K] = hi_take_left ? hi_val[L] : hi_val[R];
        end
    end

    assign any_bound = lo_act[1] || hi_act[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            proposal       <= '0;
            proposal_found <= 1'b0;
            proposal_valid <= 1'b0;
        end else begin
            proposal_valid <= bounds_valid;
            proposal_found <= bounds_valid && any_bound;
            if (bounds_valid) begin
                if (lo_act[1]) begin
                    proposal <= lo_val[1];  // a lower bound takes priority
                end else if (hi_act[1]) begin
                    proposal <= hi_val[1];
                end
                // no bound at all keeps the last proposal
            end
        end
    end

endmodule

// File: logic/clause_reduce.sv
module clause_reduce (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    propose,
    input  corner_pkg::clause_t     clause,
    input  corner_pkg::assignment_t assignment,
    input  corner_pkg::var_idx_t    move_var,
    input  logic                    enable,
    output corner_pkg::bound_t      bound
);

    // room for NUM_VARS full products plus the bias, with sign
    localparam int SUM_BITS = 2 * corner_pkg::COEF_BITS + $clog2(corner_pkg::NUM_VARS) + 2;
    localparam int PROD_BITS = 2 * corner_pkg::COEF_BITS;

    localparam corner_pkg::value_t VALUE_MAX =
        corner_pkg::value_t'(2 ** (corner_pkg::COEF_BITS - 1) - 1);
    localparam corner_pkg::value_t VALUE_MIN =
        corner_pkg::value_t'(-(2 ** (corner_pkg::COEF_BITS - 1)));

    corner_pkg::coef_t          move_coef;  // coefficient of the moved variable
    logic signed [SUM_BITS-1:0] residual;   // bias plus all other terms
    logic signed [SUM_BITS-1:0] raw_bound;
    corner_pkg::value_t         sat_bound;
    logic                       is_lower;
    logic                       is_active;

    corner_pkg::value_t         bound_value;
    logic                       bound_lower;
    logic                       bound_active;

    assign move_coef = clause.coef[move_var];

    // fold every variable except the moved one into the residual
    always_comb begin
        logic signed [PROD_BITS-1:0] product;
        residual = SUM_BITS'(clause.bias);
        for (int k = 0; k < corner_pkg::NUM_VARS; k++) begin
            product = clause.coef[k] * assignment[k];
            if (corner_pkg::var_idx_t'(k) != move_var) begin
                residual = residual + product;
            end
        end
    end

    // c*x + r > 0 with only the sign of c kept
    //   c > 0 gives x >= 1 - r
    //   c < 0 gives x <= r - 1
    assign is_lower  = ~move_coef[corner_pkg::COEF_BITS-1];
    assign is_active = enable && (move_coef != '0);

    always_comb begin
        if (is_lower) begin
            raw_bound = 1 - residual;
        end else begin
            raw_bound = residual - 1;
        end
    end

    // clamp to the value range
    always_comb begin
        if (raw_bound > VALUE_MAX) begin
            sat_bound = VALUE_MAX;
        end else if (raw_bound < VALUE_MIN) begin
            sat_bound = VALUE_MIN;
        end else begin
            sat_bound = corner_pkg::value_t'(raw_bound);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bound_active <= 1'b0;
        end else begin
            bound_active <= propose && is_active;  // drops on idle cycles
        end
    end

    always_ff @(posedge clk) begin
        if (propose) begin
            bound_value <= sat_bound;
            bound_lower <= is_lower;
        end
    end

    assign bound = '{value: bound_value, lower: bound_lower, active: bound_active};

endmodule

// File: logic/clause_store.sv
module clause_store #(
    parameter int  NUM_CLAUSES = 8,
    localparam int IDX_BITS    = $clog2(NUM_CLAUSES)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                clause_write,  // one clause per pulse
    input  logic [IDX_BITS-1:0] clause_index,
    input  corner_pkg::clause_t clause_data,
    output corner_pkg::clause_t clauses [NUM_CLAUSES]
);

    logic [NUM_CLAUSES-1:0] entry_write;  // one-hot write select

    // decode the clause index into per-entry write enables
    always_comb begin
        entry_write = '0;
        if (clause_write) begin
            entry_write[clause_index] = 1'b1;
        end
    end

    // each entry loads only when it is the selected one
    // a zero clause has all coefficients zero, so its bound is never active
    for (genvar i = 0; i < NUM_CLAUSES; i++) begin : gen_entry
        always_ff @(posedge clk) begin
            if (reset) begin
                clauses[i] <= '0;
            end else if (entry_write[i]) begin
                clauses[i] <= clause_data;
            end
        end
    end

endmodule

// File: logic/corner_pkg.sv
package corner_pkg;

    // problem size, the clause layout depends on it
    localparam int NUM_VARS = 4;

    // coefficients, biases and values share one width
    localparam int COEF_BITS = 8;

    localparam int VAR_IDX_BITS = $clog2(NUM_VARS);

    // signed coefficient or bias
    typedef logic signed [COEF_BITS-1:0] coef_t;

    // signed variable value
    // a proposal is derived from a bias, so it is as wide as coef_t
    typedef logic signed [COEF_BITS-1:0] value_t;

    typedef logic [VAR_IDX_BITS-1:0] var_idx_t;  // which variable moves

    // full assignment, element k holds variable k
    typedef value_t [NUM_VARS-1:0] assignment_t;

    // sum(coef[k] * x[k]) + bias > 0
    typedef struct packed {
        coef_t [NUM_VARS-1:0] coef;  // element k multiplies variable k
        coef_t                bias;
    } clause_t;

    // one clause reduced to a bound on the moved variable
    typedef struct packed {
        value_t value;   // saturated bound value
        logic   lower;   // 1: x >= value, 0: x <= value
        logic   active;  // clause takes part in this pass
    } bound_t;

endpackage
